// ==== sim.f ====
+incdir+design
design/cps_video_pkg.sv
design/cps_tilemap.sv
design/cps_colmix.sv
design/cps_video.sv
verification/cps_clk_gen.sv
verification/cps_video_props.sv
verification/cps_video_tb.sv

// ==== Bender.yml ====
package:
  name: cps_video

sources:
  - include_dirs:
      - design
    files:
      - design/cps_video_pkg.sv
      - design/cps_tilemap.sv
      - design/cps_colmix.sv
      - design/cps_video.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verification/cps_clk_gen.sv
      - verification/cps_video_props.sv
      - verification/cps_video_tb.sv

// ==== verification/cps_video_tb.sv ====
// Table driven testbench for the tile layer video top with memory models
`timescale 1ns/1ps
`include "cps_video_consts.svh"
`default_nettype none

module cps_video_tb;

    localparam int NUM_TESTS  = 6;
    localparam int LINE_LIMIT = 1400;               // Cycles allowed per line

    string       row_name  [NUM_TESTS] = '{"zero_scroll", "hscroll_3_21", "vscroll_base",
                                           "l1_transparent", "wr_ok_stalls", "map_wrap"};
    logic [7:0]  row_v     [NUM_TESTS] = '{8'd0, 8'd10, 8'd37, 8'd200, 8'd55, 8'd250};
    logic [15:0] row_hpos1 [NUM_TESTS] = '{16'd0, 16'd3, 16'd8, 16'd77, 16'd130, 16'd1020};
    logic [15:0] row_hpos2 [NUM_TESTS] = '{16'd0, 16'd21, 16'd40, 16'd500, 16'd262, 16'd1015};
    logic [15:0] row_vpos1 [NUM_TESTS] = '{16'd0, 16'd0, 16'd100, 16'd900, 16'd7, 16'd1000};
    logic [15:0] row_vpos2 [NUM_TESTS] = '{16'd0, 16'd0, 16'd205, 16'd13, 16'd33, 16'd1023};
    logic [15:0] row_base1 [NUM_TESTS] = '{16'h0, 16'h0, 16'h1000, 16'h0800, 16'h4000, 16'hffc0};
    logic [15:0] row_base2 [NUM_TESTS] = '{16'h0, 16'h0, 16'h2400, 16'h0040, 16'h5000, 16'hfff0};
    logic        row_stall [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    logic [7:0]              v;
    logic [15:0]             hpos1, hpos2, vpos1, vpos2, vram1_base, vram2_base;
    logic [`CPS_VRAM_AW-1:0] vram1_addr, vram2_addr;
    logic [`CPS_ROM_AW-1:0]  rom1_addr, rom2_addr;
    logic                    vram1_cs, vram2_cs, rom1_cs, rom2_cs, rom1_half, rom2_half;
    logic [`CPS_PIX_W:0]     line_data;
    logic [`CPS_X_BITS-1:0]  line_addr;
    logic                    line_wr, line_wr_ok, line_done;
    logic                    stall_en;
    logic [3:0]              mem_ok;                // VRAM1, VRAM2, ROM1, ROM2
    logic [3:0]              busy;
    logic [31:0]             mem_data [4];
    logic [2:0]              wait_cnt [4];
    logic [31:0]             lfsr;
    logic [`CPS_PIX_W:0]     expected [`CPS_LINE_W];
    int                      cycles = 0;
    int                      errors;
    int                      checks;

    cps_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    cps_video UUT (
        .*,
        .vram1_data(mem_data[0][15:0]), .vram1_ok(mem_ok[0]),
        .vram2_data(mem_data[1][15:0]), .vram2_ok(mem_ok[1]),
        .rom1_data(mem_data[2]), .rom1_ok(mem_ok[2]),
        .rom2_data(mem_data[3]), .rom2_ok(mem_ok[3])
    );

    bind cps_video cps_video_props u_props (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // Tile map contents
    function automatic logic [15:0] vram_word(input logic [15:0] addr);
        logic [31:0] m;
        m = {16'h0, addr} * 32'h9e37_79b1;
        m = m ^ (m >> 15);
        vram_word = m[15:0];
    endfunction

    // Pixel rows masked so some layer pixels are transparent
    function automatic logic [31:0] rom_word(input logic [19:0] addr);
        logic [31:0] m;
        m = {12'h0, addr} * 32'h85eb_ca6b + 32'h27d4_eb2f;
        m = m ^ (m >> 13);
        rom_word = m & (addr[0] ? 32'hf0ff_0ff0 : 32'h0ff0_f0ff);
    endfunction

    function automatic logic port_cs(input int p);
        case (p)
            0: port_cs = vram1_cs;
            1: port_cs = vram2_cs;
            2: port_cs = rom1_cs;
            default: port_cs = rom2_cs;
        endcase
    endfunction

    function automatic logic [31:0] port_word(input int p);
        case (p)
            0: port_word = {16'h0, vram_word(vram1_addr)};
            1: port_word = {16'h0, vram_word(vram2_addr)};
            2: port_word = rom_word(rom1_addr);
            default: port_word = rom_word(rom2_addr);
        endcase
    endfunction

    // Reference layer pixel at screen x for tiles of 1 << shift pixels
    function automatic logic [7:0] layer_pixel(input int shift, input logic [15:0] hpos,
                                               input logic [15:0] vpos,
                                               input logic [15:0] base, input int x);
        int          yi;
        int          hi;
        int          tsize;
        int          raddr;
        logic [15:0] word;
        logic [31:0] pix;
        tsize = 1 << shift;
        yi    = (int'(v) + int'(vpos)) % 1024;
        hi    = (x + int'(hpos)) % 1024;
        word  = vram_word(base + 16'(((yi >> shift) % 64) * `CPS_MAP_COLS + (hi >> shift) % 64));
        raddr = (int'(word[11:0]) << (shift + 1)) + ((yi % tsize) << 1) + (hi % tsize) / 8;
        pix   = rom_word(20'(raddr));
        pix   = pix >> (28 - 4 * ((hi % tsize) % 8));   // Leftmost pixel in top nibble
        layer_pixel = {word[15:12], pix[3:0]};
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s: expected %h actual %h", test, field, exp, act);
        end
    endtask

    // Memory answers and frame buffer stalls draw from one LFSR stream
    always @(posedge clk) begin
        logic [31:0] r;
        #1;
        for (int p = 0; p < 4; p++) begin
            if (mem_ok[p]) begin
                mem_ok[p] = 1'b0;
                busy[p]   = 1'b0;
            end else if (port_cs(p)) begin
                if (!busy[p]) begin
                    draw_bits(2, r);
                    wait_cnt[p] = r[2:0] + 3'd1;    // 1 to 4 cycles
                    busy[p]     = 1'b1;
                end
                wait_cnt[p] = wait_cnt[p] - 3'd1;
                if (wait_cnt[p] == 3'd0) begin
                    mem_data[p] = port_word(p);
                    mem_ok[p]   = 1'b1;
                end
            end
        end
        if (stall_en) begin
            draw_bits(1, r);
            line_wr_ok = r[0];
        end else begin
            line_wr_ok = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= NUM_TESTS * 1500) begin
            $display("run stopped at %0d cycles before all lines finished", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        logic [7:0] p1;
        logic [7:0] p2;
        int         writes;
        int         n;
        int         last_wr;
        int         first_err;
        int         rom2_reqs;
        lfsr       = 32'hd1409f38;
        start      = 1'b0;
        stall_en   = 1'b0;
        line_wr_ok = 1'b1;
        v          = '0;
        hpos1      = '0;
        hpos2      = '0;
        vpos1      = '0;
        vpos2      = '0;
        vram1_base = '0;
        vram2_base = '0;
        mem_ok     = '0;
        busy       = '0;
        errors     = 0;
        checks     = 0;
        for (int p = 0; p < 4; p++) begin
            mem_data[p] = '0;
            wait_cnt[p] = '0;
        end
        wait (rst_n === 1'b1);
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(posedge clk);
            #1;
            v          = row_v[t];
            hpos1      = row_hpos1[t];
            hpos2      = row_hpos2[t];
            vpos1      = row_vpos1[t];
            vpos2      = row_vpos2[t];
            vram1_base = row_base1[t];
            vram2_base = row_base2[t];
            stall_en  <= row_stall[t];              // Seen by the models next cycle
            for (int x = 0; x < `CPS_LINE_W; x++) begin
                p1 = layer_pixel(3, hpos1, vpos1, vram1_base, x);
                p2 = layer_pixel(4, hpos2, vpos2, vram2_base, x);
                expected[x] = (p1[3:0] != 4'd0) ? {1'b0, p1} : {1'b1, p2};  // Layer 1 on top
            end
            @(posedge clk);
            #1 start = 1'b1;
            @(posedge clk);
            #1 start = 1'b0;
            writes    = 0;
            n         = 0;
            last_wr   = -2;
            first_err = errors;
            rom2_reqs = 0;
            while (!line_done && n < LINE_LIMIT) begin
                @(negedge clk);                     // Outputs settled mid cycle
                n++;
                if (line_wr && line_wr_ok) begin
                    if (writes < `CPS_LINE_W) begin
                        check_value(row_name[t], "line_addr", writes, line_addr);
                        check_value(row_name[t], "line_data", expected[writes], line_data);
                    end
                    writes++;
                    last_wr = n;
                end
                if (rom1_cs && mem_ok[2]) begin
                    check_value(row_name[t], "rom1_half", 0, rom1_half);
                end
                if (rom2_cs && mem_ok[3]) begin     // Left half then right half of each tile
                    check_value(row_name[t], "rom2_half", rom2_reqs % 2, rom2_half);
                    rom2_reqs++;
                end
            end
            if (!line_done) begin
                errors++;
                $display("test %s: line_done did not arrive within %0d cycles",
                         row_name[t], LINE_LIMIT);
            end else if (last_wr != n - 1) begin
                errors++;
                $display("test %s: line_done came %0d cycles after the last write",
                         row_name[t], n - last_wr);
            end
            if (writes != `CPS_LINE_W) begin
                errors++;
                $display("test %s: %0d accepted writes instead of %0d",
                         row_name[t], writes, `CPS_LINE_W);
            end
            $display("test %s: %0d writes, %0d errors", row_name[t], writes, errors - first_err);
        end
        if (UUT.u_props.fail_count != 0) begin
            errors += UUT.u_props.fail_count;
            $display("%0d protocol assertions failed", UUT.u_props.fail_count);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/cps_video_props.sv ====
// Protocol assertions on the memory strobes and the frame buffer write port
`timescale 1ns/1ps
`include "cps_video_consts.svh"
`default_nettype none

module cps_video_props (
    input logic                    clk,
    input logic                    rst_n,
    input logic [`CPS_VRAM_AW-1:0] vram1_addr,
    input logic                    vram1_cs,
    input logic                    vram1_ok,
    input logic [`CPS_VRAM_AW-1:0] vram2_addr,
    input logic                    vram2_cs,
    input logic                    vram2_ok,
    input logic [`CPS_ROM_AW-1:0]  rom1_addr,
    input logic                    rom1_cs,
    input logic                    rom1_ok,
    input logic [`CPS_ROM_AW-1:0]  rom2_addr,
    input logic                    rom2_cs,
    input logic                    rom2_ok,
    input logic [`CPS_PIX_W:0]     line_data,
    input logic [`CPS_X_BITS-1:0]  line_addr,
    input logic                    line_wr,
    input logic                    line_wr_ok,
    input logic                    line_done
);

    int fail_count = 0;                             // Failed assertion count

    // Request and address stay put until the memory answers
    a_vram1_hold: assert property (@(posedge clk) disable iff (!rst_n)
        vram1_cs && !vram1_ok |=> vram1_cs && $stable(vram1_addr))
        else begin
            fail_count++;
            $error("vram1 cs or addr changed before ok");
        end
    a_vram2_hold: assert property (@(posedge clk) disable iff (!rst_n)
        vram2_cs && !vram2_ok |=> vram2_cs && $stable(vram2_addr))
        else begin
            fail_count++;
            $error("vram2 cs or addr changed before ok");
        end
    a_rom1_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rom1_cs && !rom1_ok |=> rom1_cs && $stable(rom1_addr))
        else begin
            fail_count++;
            $error("rom1 cs or addr changed before ok");
        end
    a_rom2_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rom2_cs && !rom2_ok |=> rom2_cs && $stable(rom2_addr))
        else begin
            fail_count++;
            $error("rom2 cs or addr changed before ok");
        end

    a_line_hold: assert property (@(posedge clk) disable iff (!rst_n)
        line_wr && !line_wr_ok |=> line_wr && $stable(line_addr) && $stable(line_data))
        else begin
            fail_count++;
            $error("line write fields moved while stalled");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        line_done |=> !line_done)
        else begin
            fail_count++;
            $error("line_done held longer than one cycle");
        end

endmodule

`default_nettype wire

// ==== verification/cps_clk_gen.sv ====
// Testbench clock and power-on reset source for the video top
`timescale 1ns/1ps
`default_nettype none

module cps_clk_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;                            // Release just after the edge
    end

endmodule

`default_nettype wire

// ==== design/cps_video.sv ====
// Tile layer video top joining two scroll engines to the color mixer
`timescale 1ns/1ps
`include "cps_video_consts.svh"
`default_nettype none

module cps_video (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              v,
    input  logic                    start,
    // Scroll registers
    input  logic [15:0]             hpos1,
    input  logic [15:0]             hpos2,
    input  logic [15:0]             vpos1,
    input  logic [15:0]             vpos2,
    input  logic [15:0]             vram1_base,
    input  logic [15:0]             vram2_base,
    // Tile map memories
    output logic [`CPS_VRAM_AW-1:0] vram1_addr,
    output logic                    vram1_cs,
    input  logic [15:0]             vram1_data,
    input  logic                    vram1_ok,
    output logic [`CPS_VRAM_AW-1:0] vram2_addr,
    output logic                    vram2_cs,
    input  logic [15:0]             vram2_data,
    input  logic                    vram2_ok,
    // Graphics ROMs
    output logic [`CPS_ROM_AW-1:0]  rom1_addr,
    output logic                    rom1_half,
    output logic                    rom1_cs,
    input  logic [31:0]             rom1_data,
    input  logic                    rom1_ok,
    output logic [`CPS_ROM_AW-1:0]  rom2_addr,
    output logic                    rom2_half,
    output logic                    rom2_cs,
    input  logic [31:0]             rom2_data,
    input  logic                    rom2_ok,
    // Frame buffer
    output logic [`CPS_PIX_W:0]     line_data,
    output logic [`CPS_X_BITS-1:0]  line_addr,
    output logic                    line_wr,
    input  logic                    line_wr_ok,
    output logic                    line_done
);

    logic [`CPS_X_BITS-1:0] buf1_addr, buf2_addr;
    logic [`CPS_PIX_W-1:0]  buf1_data, buf2_data;
    logic                   buf1_wr, buf2_wr;
    logic [2:1]             scr_done;

    // Scroll 1 uses 8x8 tiles
    cps_tilemap #(.SIZE(8)) u_scroll1 (
        .clk(clk), .rst_n(rst_n), .v(v), .start(start),
        .vram_base(vram1_base), .hpos(hpos1), .vpos(vpos1),
        .vram_addr(vram1_addr), .vram_cs(vram1_cs),
        .vram_data(vram1_data), .vram_ok(vram1_ok),
        .rom_addr(rom1_addr), .rom_half(rom1_half), .rom_cs(rom1_cs),
        .rom_data(rom1_data), .rom_ok(rom1_ok),
        .buf_addr(buf1_addr), .buf_data(buf1_data), .buf_wr(buf1_wr),
        .done(scr_done[1])
    );

    // Scroll 2 uses 16x16 tiles, two ROM words per row
    cps_tilemap #(.SIZE(16)) u_scroll2 (
        .clk(clk), .rst_n(rst_n), .v(v), .start(start),
        .vram_base(vram2_base), .hpos(hpos2), .vpos(vpos2),
        .vram_addr(vram2_addr), .vram_cs(vram2_cs),
        .vram_data(vram2_data), .vram_ok(vram2_ok),
        .rom_addr(rom2_addr), .rom_half(rom2_half), .rom_cs(rom2_cs),
        .rom_data(rom2_data), .rom_ok(rom2_ok),
        .buf_addr(buf2_addr), .buf_data(buf2_data), .buf_wr(buf2_wr),
        .done(scr_done[2])
    );

    cps_colmix u_colmix (
        .clk(clk), .rst_n(rst_n), .start(start),
        .scr1_addr(buf1_addr), .scr1_data(buf1_data), .scr1_wr(buf1_wr),
        .scr2_addr(buf2_addr), .scr2_data(buf2_data), .scr2_wr(buf2_wr),
        .scr_done(scr_done),
        .line_data(line_data), .line_addr(line_addr), .line_wr(line_wr),
        .line_wr_ok(line_wr_ok), .line_done(line_done)
    );

endmodule

`default_nettype wire

// ==== design/cps_colmix.sv ====
// Color mixer merging two layer line buffers and writing the frame buffer line
`timescale 1ns/1ps
`include "cps_video_consts.svh"
`default_nettype none

module cps_colmix (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    // Layer pixel writes
    input  logic [`CPS_X_BITS-1:0] scr1_addr,
    input  logic [`CPS_PIX_W-1:0]  scr1_data,
    input  logic                   scr1_wr,
    input  logic [`CPS_X_BITS-1:0] scr2_addr,
    input  logic [`CPS_PIX_W-1:0]  scr2_data,
    input  logic                   scr2_wr,
    input  logic [2:1]             scr_done,
    // Frame buffer
    output logic [`CPS_PIX_W:0]    line_data,
    output logic [`CPS_X_BITS-1:0] line_addr,
    output logic                   line_wr,
    input  logic                   line_wr_ok,
    output logic                   line_done
);

    localparam int X_BITS = `CPS_X_BITS;
    localparam logic [X_BITS-1:0] X_LAST = X_BITS'(`CPS_LINE_W - 1);

    cps_video_pkg::mix_state_e state;

    logic [`CPS_PIX_W-1:0] buf1 [`CPS_LINE_W];
    logic [`CPS_PIX_W-1:0] buf2 [`CPS_LINE_W];
    logic [`CPS_PIX_W-1:0] pix1;
    logic [`CPS_PIX_W-1:0] pix2;
    logic [2:1]            done_seen;               // Sticky layer done flags
    logic [2:1]            done_all;
    logic [X_BITS-1:0]     x;

    always_ff @(posedge clk) begin
        if (scr1_wr) begin
            buf1[scr1_addr] <= scr1_data;
        end
        if (scr2_wr) begin
            buf2[scr2_addr] <= scr2_data;
        end
    end

    assign pix1 = buf1[x];
    assign pix2 = buf2[x];

    // Layer 1 on top unless its color is 0
    assign line_data = (pix1[3:0] != 4'd0) ? {1'b0, pix1} : {1'b1, pix2};
    assign line_addr = x;
    assign line_wr   = (state == cps_video_pkg::MERGE);
    assign done_all  = done_seen | scr_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= cps_video_pkg::FINISH;
            done_seen <= 2'b00;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            case (state)
                cps_video_pkg::FINISH: begin
                    if (start) begin
                        done_seen <= 2'b00;         // New line
                        state     <= cps_video_pkg::FILL;
                    end
                end
                cps_video_pkg::FILL: begin
                    done_seen <= done_all;
                    if (done_all == 2'b11) begin
                        x     <= '0;
                        state <= cps_video_pkg::MERGE;
                    end
                end
                cps_video_pkg::MERGE: begin
                    if (line_wr_ok) begin           // Step only on accepted write
                        x <= x + 1'b1;
                        if (x == X_LAST) begin
                            line_done <= 1'b1;
                            state     <= cps_video_pkg::FINISH;
                        end
                    end
                end
                default: state <= cps_video_pkg::FINISH;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/cps_tilemap.sv ====
// Scroll layer engine fetching tile codes and pixel rows to draw one scanline
`timescale 1ns/1ps
`include "cps_video_consts.svh"
`default_nettype none

module cps_tilemap #(
    parameter int SIZE = 8                          // Tile edge, 8 or 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              v,
    input  logic                    start,
    input  logic [15:0]             vram_base,
    input  logic [15:0]             hpos,
    input  logic [15:0]             vpos,
    // Tile map memory
    output logic [`CPS_VRAM_AW-1:0] vram_addr,
    output logic                    vram_cs,
    input  logic [15:0]             vram_data,
    input  logic                    vram_ok,
    // Graphics ROM
    output logic [`CPS_ROM_AW-1:0]  rom_addr,
    output logic                    rom_half,
    output logic                    rom_cs,
    input  logic [31:0]             rom_data,
    input  logic                    rom_ok,
    // Layer line buffer
    output logic [`CPS_X_BITS-1:0]  buf_addr,
    output logic [`CPS_PIX_W-1:0]   buf_data,
    output logic                    buf_wr,
    output logic                    done
);

    localparam int TILE_SHIFT = $clog2(SIZE);
    localparam int HALVES     = SIZE / 8;             // ROM words per tile row
    localparam int COL_BITS   = $clog2(`CPS_MAP_COLS);
    localparam int VRAM_AW    = `CPS_VRAM_AW;
    localparam int ROM_AW     = `CPS_ROM_AW;
    localparam int X_BITS     = `CPS_X_BITS;
    localparam logic [9:0] ROW_MASK = 10'(SIZE - 1);
    localparam logic [X_BITS-1:0] X_LAST = X_BITS'(`CPS_LINE_W - 1);

    cps_video_pkg::tilemap_state_e state;

    logic [9:0]            y;                          // Scrolled line
    logic [COL_BITS-1:0]   col;                        // Current map column
    logic [COL_BITS-1:0]   map_row;
    logic [TILE_SHIFT-1:0] tile_row;
    logic [TILE_SHIFT-1:0] skip;                       // Pixels left of screen edge
    logic [X_BITS-1:0]     x;
    logic [11:0]           code;
    logic [3:0]            pal;
    logic                  half;
    logic [31:0]           pix_row;
    logic [2:0]            p;                          // Pixel within ROM word

    // Map wraps at 64 rows and 64 columns
    assign map_row   = y[TILE_SHIFT +: COL_BITS];
    assign tile_row  = y[TILE_SHIFT-1:0];
    assign vram_addr = vram_base + VRAM_AW'({map_row, col});
    assign rom_addr  = ROM_AW'({code, tile_row, half});
    assign rom_half  = half;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= cps_video_pkg::IDLE;
            vram_cs <= 1'b0;
            rom_cs  <= 1'b0;
            buf_wr  <= 1'b0;
            done    <= 1'b0;
        end else begin
            buf_wr <= 1'b0;
            done   <= 1'b0;
            case (state)
                cps_video_pkg::IDLE: begin
                    if (start) begin
                        y       <= {2'b00, v} + vpos[9:0];
                        col     <= hpos[TILE_SHIFT +: COL_BITS];
                        skip    <= TILE_SHIFT'(hpos[9:0] & ROW_MASK);
                        x       <= '0;
                        vram_cs <= 1'b1;
                        state   <= cps_video_pkg::MAP_RD;
                    end
                end
                cps_video_pkg::MAP_RD: begin
                    if (vram_ok) begin
                        code    <= vram_data[11:0];
                        pal     <= vram_data[15:12];
                        half    <= 1'b0;
                        vram_cs <= 1'b0;
                        rom_cs  <= 1'b1;
                        state   <= cps_video_pkg::ROM_RD;
                    end
                end
                cps_video_pkg::ROM_RD: begin
                    if (rom_ok) begin
                        pix_row <= rom_data;
                        p       <= 3'd0;
                        rom_cs  <= 1'b0;
                        state   <= cps_video_pkg::DRAW;
                    end
                end
                cps_video_pkg::DRAW: begin
                    pix_row <= pix_row << 4;            // Next nibble to the top
                    p       <= p + 3'd1;
                    if (skip != '0) begin
                        skip <= skip - 1'b1;
                    end else begin
                        buf_wr   <= 1'b1;
                        buf_addr <= x;
                        buf_data <= {pal, pix_row[31:28]};
                        x        <= x + 1'b1;
                    end
                    if (skip == '0 && x == X_LAST) begin
                        state <= cps_video_pkg::DONE;
                    end else if (p == 3'd7) begin
                        if (half == 1'(HALVES - 1)) begin
                            // Tile finished, move right one column
                            col     <= col + 1'b1;
                            vram_cs <= 1'b1;
                            state   <= cps_video_pkg::MAP_RD;
                        end else begin
                            half   <= 1'b1;             // Right 8 pixels of a 16 tile
                            rom_cs <= 1'b1;
                            state  <= cps_video_pkg::ROM_RD;
                        end
                    end
                end
                cps_video_pkg::DONE: begin
                    done  <= 1'b1;
                    state <= cps_video_pkg::IDLE;
                end
                default: state <= cps_video_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/cps_video_pkg.sv ====
// Shared state types for the tilemap engine and the color mixer
`default_nettype none

package cps_video_pkg;

    // Tilemap engine sequencing
    typedef enum logic [2:0] {
        IDLE,       // Waiting for start
        MAP_RD,     // Tile code fetch
        ROM_RD,     // Pixel row fetch
        DRAW,       // Unpack 8 pixels
        DONE        // End of line pulse
    } tilemap_state_e;

    // Mixer sequencing, FINISH doubles as idle
    typedef enum logic [1:0] {
        FILL,
        MERGE,
        FINISH
    } mix_state_e;

endpackage

`default_nettype wire

// ==== design/cps_video_consts.svh ====
// Video line constants shared by the tile layers and the color mixer
`default_nettype none

`ifndef CPS_VIDEO_CONSTS_SVH
`define CPS_VIDEO_CONSTS_SVH

// Scanline geometry
`define CPS_LINE_W      128
`define CPS_X_BITS      7

// Tile map is 64 columns wide, row stride in VRAM words
`define CPS_MAP_COLS    64

// VRAM word: palette in [15:12], tile code in [11:0]
`define CPS_VRAM_AW     16

// ROM word holds 8 pixels, leftmost in high nibble
`define CPS_ROM_AW      20

// Layer pixel is palette and color
`define CPS_PIX_W       8

`endif

`default_nettype wire
